// ==== isa_pkg.sv ====
package isa_pkg;

    localparam int WORD_W    = 16;
    localparam int OPCODE_W  = 8;
    localparam int REG_IDX_W = 3;
    localparam int COND_W    = 4;
    localparam int ALU_CTL_W = 8;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [OPCODE_W-1:0]  opcode_t;  // Bits 15 to 8 of a word.
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [COND_W-1:0]    cond_t;
    typedef logic [ALU_CTL_W-1:0] alu_ctl_t;

    localparam reg_idx_t SP_IDX = 3'd7;  // Stack pointer.

    // ALU group.
    localparam opcode_t ADD     = 8'h01;
    localparam opcode_t SUB     = 8'h02;
    localparam opcode_t AND     = 8'h03;
    localparam opcode_t OR      = 8'h04;
    localparam opcode_t XOR     = 8'h05;
    localparam opcode_t MOV     = 8'h06;

    // Memory and stack group.
    localparam opcode_t LD      = 8'h10;
    localparam opcode_t ST      = 8'h11;
    localparam opcode_t PUSH    = 8'h12;
    localparam opcode_t POP     = 8'h13;
    localparam opcode_t PUSHLR  = 8'h14;

    // Control flow.
    localparam opcode_t JMP     = 8'h20;
    localparam opcode_t CALL    = 8'h21;
    localparam opcode_t SET     = 8'h22;
    localparam opcode_t SPEC    = 8'h23;

    // Byte move, target register in the low opcode bits.
    localparam opcode_t MOVB_R0 = 8'h38;
    localparam opcode_t MOVB_R1 = 8'h39;
    localparam opcode_t MOVB_R2 = 8'h3A;
    localparam opcode_t MOVB_R3 = 8'h3B;
    localparam opcode_t MOVB_R4 = 8'h3C;
    localparam opcode_t MOVB_R5 = 8'h3D;
    localparam opcode_t MOVB_R6 = 8'h3E;
    localparam opcode_t MOVB_R7 = 8'h3F;

    // Bit 7 set, a 16-bit immediate word follows.
    localparam opcode_t LDI     = 8'h90;
    localparam opcode_t STI     = 8'h91;
    localparam opcode_t PUSHI   = 8'h92;
    localparam opcode_t JMPI    = 8'hA0;
    localparam opcode_t CALLI   = 8'hA1;

endpackage

// ==== pipe_pkg.sv ====
package pipe_pkg;

    localparam int QUEUE_DEPTH = 4;  // Also the fetch side credit count.
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int OUT_CREDITS = 2;  // One per execute slot.
    localparam int CREDIT_W    = 3;

    typedef logic [CREDIT_W-1:0]    credit_cnt_t;
    typedef logic [QUEUE_PTR_W-1:0] queue_ptr_t;

    typedef struct packed {
        isa_pkg::alu_ctl_t alu_ctl;
        isa_pkg::reg_idx_t rd_sel;
        isa_pkg::reg_idx_t rs_sel;
        isa_pkg::word_t    immediate;
        logic              en_imm;
        logic              en_mem;
        logic              mem_disp;     // Displacement addressing.
        logic              mem_byte;     // Byte access.
        logic              lr_is_input;
        isa_pkg::cond_t    condition;
    } uop_t;

    // Decoder output, need_ext marks a pending extension word.
    typedef struct packed {
        uop_t uop;
        logic need_ext;
    } dec_t;

endpackage

// ==== instr_queue.sv ====
module instr_queue (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           in_valid,
    input  isa_pkg::word_t in_word,
    output logic           in_credit,
    output logic           q_valid,
    input  logic           q_ready,
    output isa_pkg::word_t q_word
);

    isa_pkg::word_t        mem [pipe_pkg::QUEUE_DEPTH];
    pipe_pkg::queue_ptr_t  wr_ptr;
    pipe_pkg::queue_ptr_t  rd_ptr;
    pipe_pkg::credit_cnt_t count;
    logic                  full;
    logic                  push;
    logic                  pop;
    logic                  overflow;

    function automatic pipe_pkg::queue_ptr_t ptr_inc(input pipe_pkg::queue_ptr_t ptr);
        if (ptr == pipe_pkg::queue_ptr_t'(pipe_pkg::QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full      = (count == pipe_pkg::credit_cnt_t'(pipe_pkg::QUEUE_DEPTH));
    assign q_valid   = (count != '0);
    assign q_word    = mem[rd_ptr];
    assign pop       = q_valid && q_ready;
    assign in_credit = pop;  // One credit back per popped word.

    // A write into a full queue is only legal alongside a pop.
    assign overflow  = in_valid && full && !pop;
    assign push      = in_valid && !overflow;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_word;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Idle or push and pop together.
            endcase
        end
    end

endmodule

// ==== instr_decoder.sv ====
module instr_decoder (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           in_valid,
    output logic           in_ready,
    input  isa_pkg::word_t in_word,
    output logic           d_valid,
    input  logic           d_ready,
    output pipe_pkg::dec_t d_dec
);

    isa_pkg::opcode_t opcode;
    pipe_pkg::dec_t   dec_nxt;
    logic             accept;

    assign opcode   = in_word[15:8];
    assign in_ready = d_ready || !d_valid;  // Empty or being drained.
    assign accept   = in_valid && in_ready;

    always_comb begin
        dec_nxt          = '0;
        dec_nxt.need_ext = opcode[7];

        // Register and immediate fields.
        case (opcode)
            isa_pkg::MOVB_R0,
            isa_pkg::MOVB_R1,
            isa_pkg::MOVB_R2,
            isa_pkg::MOVB_R3,
            isa_pkg::MOVB_R4,
            isa_pkg::MOVB_R5,
            isa_pkg::MOVB_R6,
            isa_pkg::MOVB_R7: begin
                dec_nxt.uop.alu_ctl   = isa_pkg::MOV;
                dec_nxt.uop.rd_sel    = opcode[2:0];
                dec_nxt.uop.immediate = {8'h00, in_word[7:0]};
                dec_nxt.uop.en_imm    = 1'b1;
            end
            default: begin
                dec_nxt.uop.alu_ctl = {1'b0, opcode[6:0]};
                dec_nxt.uop.rd_sel  = in_word[2:0];
                dec_nxt.uop.rs_sel  = in_word[5:3];
                dec_nxt.uop.en_imm  = opcode[7];  // Immediate comes later.
            end
        endcase

        // Memory, link register and condition fields.
        case (opcode)
            isa_pkg::LD,
            isa_pkg::ST: begin
                dec_nxt.uop.en_mem   = 1'b1;
                dec_nxt.uop.mem_byte = in_word[7];
            end
            isa_pkg::LDI,
            isa_pkg::STI: begin
                dec_nxt.uop.en_mem   = 1'b1;
                dec_nxt.uop.mem_byte = in_word[7];
                dec_nxt.uop.mem_disp = in_word[6];
            end
            isa_pkg::PUSH,
            isa_pkg::POP,
            isa_pkg::PUSHI: begin
                dec_nxt.uop.en_mem = 1'b1;
                dec_nxt.uop.rs_sel = isa_pkg::SP_IDX ^ in_word[5:3];  // Zero field is SP.
            end
            isa_pkg::PUSHLR: begin
                dec_nxt.uop.en_mem      = 1'b1;
                dec_nxt.uop.rs_sel      = isa_pkg::SP_IDX ^ in_word[5:3];
                dec_nxt.uop.lr_is_input = 1'b1;
            end
            isa_pkg::SPEC: begin
                dec_nxt.uop.lr_is_input = 1'b1;
            end
            isa_pkg::JMP,
            isa_pkg::JMPI,
            isa_pkg::CALL,
            isa_pkg::CALLI,
            isa_pkg::SET: begin
                dec_nxt.uop.condition = in_word[6:3];
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            d_valid <= 1'b0;
        end else if (accept) begin
            d_valid <= 1'b1;
        end else if (d_ready) begin
            d_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            d_dec <= dec_nxt;
        end
    end

endmodule

// ==== uop_assembler.sv ====
module uop_assembler (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           d_valid,
    output logic           d_ready,
    input  pipe_pkg::dec_t d_dec,
    input  logic           q_valid,
    input  isa_pkg::word_t q_word,
    output logic           ext_take,
    output logic           out_valid,
    output pipe_pkg::uop_t out_uop,
    input  logic           out_credit
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_EXT,
        SEND
    } asm_state_t;

    asm_state_t            state;
    asm_state_t            state_nxt;
    pipe_pkg::uop_t        uop_q;
    pipe_pkg::credit_cnt_t credits;
    logic                  send;
    logic                  take_dec;
    logic                  take_ext;

    assign send      = (state == SEND) && (credits != '0);
    assign d_ready   = (state == IDLE) || send;
    assign take_dec  = d_valid && d_ready;
    assign out_valid = send;
    assign out_uop   = uop_q;

    // The extension word sits right behind its instruction in the queue, so it
    // is claimed from the cycle the instruction is taken, before the decoder.
    assign ext_take  = (state == WAIT_EXT) || (take_dec && d_dec.need_ext);
    assign take_ext  = ext_take && q_valid;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE,
            SEND: begin
                if (take_dec) begin
                    if (d_dec.need_ext && !take_ext) begin
                        state_nxt = WAIT_EXT;
                    end else begin
                        state_nxt = SEND;
                    end
                end else if (send) begin
                    state_nxt = IDLE;
                end
            end
            WAIT_EXT: begin
                if (take_ext) begin
                    state_nxt = SEND;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= IDLE;
            credits <= pipe_pkg::credit_cnt_t'(pipe_pkg::OUT_CREDITS);
        end else begin
            state <= state_nxt;
            case ({out_credit, send})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;  // None or one in and one out.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take_dec) begin
            uop_q <= d_dec.uop;
        end
        if (take_ext) begin
            uop_q.immediate <= q_word;  // Overrides the decoded zero.
        end
    end

endmodule

// ==== decode_stage.sv ====
module decode_stage (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           in_valid,
    input  isa_pkg::word_t in_word,
    output logic           in_credit,
    output logic           out_valid,
    output pipe_pkg::uop_t out_uop,
    input  logic           out_credit
);

    logic           q_valid;
    logic           q_ready;
    isa_pkg::word_t q_word;
    logic           dec_in_valid;
    logic           dec_in_ready;
    logic           d_valid;
    logic           d_ready;
    pipe_pkg::dec_t d_dec;
    logic           ext_take;

    // Extension words go straight to the assembler.
    assign q_ready      = ext_take || dec_in_ready;
    assign dec_in_valid = q_valid && !ext_take;

    instr_queue u_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_word   (in_word),
        .in_credit (in_credit),
        .q_valid   (q_valid),
        .q_ready   (q_ready),
        .q_word    (q_word)
    );

    instr_decoder u_decoder (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (dec_in_valid),
        .in_ready (dec_in_ready),
        .in_word  (q_word),
        .d_valid  (d_valid),
        .d_ready  (d_ready),
        .d_dec    (d_dec)
    );

    uop_assembler u_assembler (
        .clk        (clk),
        .rst_n      (rst_n),
        .d_valid    (d_valid),
        .d_ready    (d_ready),
        .d_dec      (d_dec),
        .q_valid    (q_valid),
        .q_word     (q_word),
        .ext_take   (ext_take),
        .out_valid  (out_valid),
        .out_uop    (out_uop),
        .out_credit (out_credit)
    );

endmodule

// ==== decode_stage_props.sv ====
module decode_stage_props (
    input logic           clk,
    input logic           rst_n,
    input logic           in_valid,
    input logic           q_valid,
    input logic           q_ready,
    input logic           out_valid,
    input logic           out_credit,
    input logic           d_valid,
    input logic           d_ready,
    input pipe_pkg::dec_t d_dec
);
    timeunit 1ns;
    timeprecision 1ps;

    int q_fill;        // Words held by the queue.
    int exec_credits;  // Credits the assembler holds.
    int fail_cnt = 0;  // Failed assertions so far.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            q_fill       <= 0;
            exec_credits <= pipe_pkg::OUT_CREDITS;
        end else begin
            q_fill       <= q_fill + int'(in_valid) - int'(q_valid && q_ready);
            exec_credits <= exec_credits + int'(out_credit) - int'(out_valid);
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> ((q_fill < pipe_pkg::QUEUE_DEPTH) || (q_valid && q_ready)))
        else begin
            fail_cnt++;
            $error("Word written into a full queue");
        end

    a_credit_limit: assert property (@(posedge clk) disable iff (!rst_n)
        (exec_credits <= pipe_pkg::OUT_CREDITS) && (!out_valid || exec_credits > 0))
        else begin
            fail_cnt++;
            $error("Output credit count out of range");
        end

    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (d_valid && !d_ready) |=> (d_valid && $stable(d_dec)))
        else begin
            fail_cnt++;
            $error("Decoder output changed under a stall");
        end

endmodule

bind decode_stage decode_stage_props u_props (.*);

// ==== tb_decode_stage.sv ====
module tb_decode_stage;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_OPCODES = 28;
    localparam int N_RANDOM  = 300;
    localparam int N_STALL   = 20;

    logic             clk;
    logic             rst_n;
    logic             in_valid;
    isa_pkg::word_t   in_word;
    logic             in_credit;
    logic             out_valid;
    pipe_pkg::uop_t   out_uop;
    logic             out_credit;

    logic [31:0]      lfsr;
    logic [31:0]      rnd_drv;
    logic [31:0]      rnd_gen;
    isa_pkg::opcode_t opcode_map [N_OPCODES];
    isa_pkg::word_t   word_q [$];  // Words not yet sent.
    pipe_pkg::uop_t   exp_q [$];   // Expected micro-ops in order.
    int               fetch_credits;
    int               held;        // Micro-ops whose credit is still out.
    int               n_sent;
    int               n_recv;
    int               in_credit_cnt;
    int               n_checks;
    int               errors;
    logic             withhold;

    decode_stage u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_word    (in_word),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_uop    (out_uop),
        .out_credit (out_credit)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic draw(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = next_lfsr(lfsr);
            bits = {bits[30:0], lfsr[0]};
        end
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        n_checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    function automatic pipe_pkg::uop_t ref_decode(input isa_pkg::word_t w,
                                                  input isa_pkg::word_t ext);
        isa_pkg::opcode_t op;
        pipe_pkg::uop_t   u;
        op = w[15:8];
        u  = '0;
        if (op >= isa_pkg::MOVB_R0 && op <= isa_pkg::MOVB_R7) begin
            u.alu_ctl   = isa_pkg::MOV;
            u.rd_sel    = op[2:0];  // Target register sits in the opcode.
            u.immediate = {8'h00, w[7:0]};
            u.en_imm    = 1'b1;
        end else begin
            u.alu_ctl   = {1'b0, op[6:0]};
            u.rd_sel    = w[2:0];
            u.rs_sel    = w[5:3];
            u.en_imm    = op[7];
            u.immediate = op[7] ? ext : '0;
        end
        if (op == isa_pkg::LD || op == isa_pkg::ST || op == isa_pkg::LDI
                || op == isa_pkg::STI) begin
            u.en_mem   = 1'b1;
            u.mem_byte = w[7];
        end
        if (op == isa_pkg::LDI || op == isa_pkg::STI) begin
            u.mem_disp = w[6];
        end
        if (op == isa_pkg::PUSH || op == isa_pkg::POP || op == isa_pkg::PUSHI
                || op == isa_pkg::PUSHLR) begin
            u.en_mem = 1'b1;
            u.rs_sel = ~w[5:3];  // Points at the stack pointer.
        end
        u.lr_is_input = (op == isa_pkg::SPEC || op == isa_pkg::PUSHLR);
        if (op == isa_pkg::JMP || op == isa_pkg::JMPI || op == isa_pkg::CALL
                || op == isa_pkg::CALLI || op == isa_pkg::SET) begin
            u.condition = w[6:3];
        end
        return u;
    endfunction

    task automatic queue_instr(input isa_pkg::opcode_t op);
        isa_pkg::word_t w;
        isa_pkg::word_t ext;
        logic [31:0]    r;
        draw(8, r);
        w   = {op, r[7:0]};
        ext = '0;
        word_q.push_back(w);
        if (op[7]) begin
            draw(16, r);
            ext = r[15:0];
            word_q.push_back(ext);  // Extension word follows.
        end
        exp_q.push_back(ref_decode(w, ext));
        n_sent++;
    endtask

    task automatic wait_drained(input int limit, input string what);
        int cycles;
        cycles = 0;
        while ((word_q.size() != 0 || exp_q.size() != 0) && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (cycles >= limit) begin
            errors++;
            $display("Timeout in %s with %0d words unsent and %0d micro-ops missing",
                     what, word_q.size(), exp_q.size());
        end
    endtask

    task automatic wait_credits_back(input int limit);
        int cycles;
        cycles = 0;
        while (held != 0 && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (cycles >= limit) begin
            errors++;
            $display("Timeout with %0d output credits never returned", held);
        end
    endtask

    task automatic report_test(input string name, input int mark);
        $display("test %s done, %0d errors", name, errors - mark);
    endtask

    // Fetch and execute side models, both act mid-cycle.
    always @(negedge clk) begin
        if (!rst_n) begin
            in_valid   <= 1'b0;
            out_credit <= 1'b0;
        end else begin
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("A micro-op came out at %0t ns with none expected", $time);
                end else begin
                    check("out_uop", out_uop, exp_q.pop_front());
                end
                n_recv++;
                held++;
            end
            in_valid <= 1'b0;
            if (fetch_credits > 0 && word_q.size() > 0) begin
                draw(2, rnd_drv);
                if (rnd_drv[1:0] != 2'b00) begin
                    in_valid <= 1'b1;
                    in_word  <= word_q.pop_front();
                    fetch_credits--;
                end
            end
            if (in_credit) begin
                fetch_credits++;
                in_credit_cnt++;
            end
            out_credit <= 1'b0;
            if (!withhold && held > 0) begin
                draw(1, rnd_drv);
                if (rnd_drv[0]) begin
                    out_credit <= 1'b1;
                    held--;
                end
            end
        end
    end

    initial begin
        int mark;
        clk           = 1'b0;
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        in_word       = '0;
        out_credit    = 1'b0;
        lfsr          = 32'hec003dc5;
        fetch_credits = pipe_pkg::QUEUE_DEPTH;
        held          = 0;
        n_sent        = 0;
        n_recv        = 0;
        in_credit_cnt = 0;
        n_checks      = 0;
        errors        = 0;
        withhold      = 1'b0;
        opcode_map = '{isa_pkg::ADD, isa_pkg::SUB, isa_pkg::AND, isa_pkg::OR, isa_pkg::XOR,
                       isa_pkg::MOV, isa_pkg::LD, isa_pkg::ST, isa_pkg::PUSH, isa_pkg::POP,
                       isa_pkg::PUSHLR, isa_pkg::JMP, isa_pkg::CALL, isa_pkg::SET, isa_pkg::SPEC,
                       isa_pkg::MOVB_R0, isa_pkg::MOVB_R1, isa_pkg::MOVB_R2, isa_pkg::MOVB_R3,
                       isa_pkg::MOVB_R4, isa_pkg::MOVB_R5, isa_pkg::MOVB_R6, isa_pkg::MOVB_R7,
                       isa_pkg::LDI, isa_pkg::STI, isa_pkg::PUSHI, isa_pkg::JMPI, isa_pkg::CALLI};
        repeat (16) @(negedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        mark = errors;
        for (int i = 0; i < N_OPCODES; i++) begin
            queue_instr(opcode_map[i]);
        end
        wait_drained(2000, "opcode_sweep");
        report_test("opcode_sweep", mark);

        mark = errors;
        for (int i = 0; i < N_RANDOM; i++) begin
            draw(5, rnd_gen);
            queue_instr(opcode_map[rnd_gen % N_OPCODES]);
        end
        wait_drained(20000, "random_mix");
        report_test("random_mix", mark);

        mark = errors;
        withhold = 1'b1;
        for (int i = 0; i < N_STALL; i++) begin
            draw(5, rnd_gen);
            queue_instr(opcode_map[rnd_gen % N_OPCODES]);
        end
        repeat (40) @(posedge clk);  // Long enough for the queue to fill.
        in_credit_cnt = 0;
        repeat (20) @(posedge clk);
        check("in_credit pulses", in_credit_cnt, 0);
        check("fetch credits", fetch_credits, 0);
        withhold = 1'b0;
        wait_drained(2000, "credit_stall");
        report_test("credit_stall", mark);

        mark = errors;
        wait_credits_back(500);
        @(negedge clk);
        check("micro-ops received", n_recv, n_sent);
        check("fetch credits", fetch_credits, pipe_pkg::QUEUE_DEPTH);
        check("output credits", u_dut.u_assembler.credits, pipe_pkg::OUT_CREDITS);
        check("assertion failures", u_dut.u_props.fail_cnt, 0);
        report_test("final_counts", mark);

        $display("checks %0d, errors %0d", n_checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
isa_pkg.sv
pipe_pkg.sv
instr_queue.sv
instr_decoder.sv
uop_assembler.sv
decode_stage.sv
decode_stage_props.sv
tb_decode_stage.sv

// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - isa_pkg.sv
  - pipe_pkg.sv
  - instr_queue.sv
  - instr_decoder.sv
  - uop_assembler.sv
  - decode_stage.sv
  - target: simulation
    files:
      - decode_stage_props.sv
      - tb_decode_stage.sv
